//--- design/read_guard_pkg.sv
package read_guard_pkg;

  // Bus transaction ID
  typedef logic [3:0] id_t;

  // Read address
  typedef logic [31:0] addr_t;

  // Burst length minus one
  typedef logic [7:0] len_t;

  // Budget and timer word
  typedef logic [15:0] cnt_t;

  // Snapshot of the read address channel
  typedef struct packed {
    logic  valid;
    logic  ready;
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_mon_t;

  // Snapshot of the read data channel
  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
    logic last;
  } r_mon_t;

  // Time budgets, in clock cycles
  typedef struct packed {
    cnt_t first_beat;
    cnt_t per_beat;
  } budgets_t;

  typedef enum logic [2:0] {
    NONE,
    FIRST_TIMEOUT,
    BURST_TIMEOUT,
    POOL_OVERFLOW,
    STRAY_BEAT
  } fault_cause_e;

  // One fault event
  typedef struct packed {
    logic         valid;
    fault_cause_e cause;
    id_t          id;
    addr_t        addr;
  } fault_t;

endpackage

//--- design/read_slot_pool.sv
`timescale 1ns/100ps

module read_slot_pool #(
  parameter int unsigned MaxRdTxns = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  read_guard_pkg::ar_mon_t   ar_i,
  input  read_guard_pkg::r_mon_t    r_i,
  input  read_guard_pkg::budgets_t  budgets_i,
  output read_guard_pkg::fault_t    fault_o
);

  // Wide enough for a slot index and for an age
  localparam int unsigned SlotW = (MaxRdTxns > 1) ? $clog2(MaxRdTxns) : 1;
  // Product of per-beat budget and beat count
  localparam int unsigned LimW = $bits(read_guard_pkg::cnt_t) + $bits(read_guard_pkg::len_t) + 1;

  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT,
    SLOT_BURST
  } slot_state_e;

  typedef struct packed {
    slot_state_e           state;
    read_guard_pkg::id_t   id;
    read_guard_pkg::addr_t addr;
    read_guard_pkg::len_t  len;
    read_guard_pkg::cnt_t  timer;
    logic [SlotW-1:0]      age;
  } slot_t;

  slot_t slots_q [MaxRdTxns];
  slot_t slots_d [MaxRdTxns];

  logic                   ar_hs;
  logic                   r_hs;
  logic [MaxRdTxns-1:0]   live;
  logic [MaxRdTxns-1:0]   first_to;
  logic [MaxRdTxns-1:0]   burst_to;
  logic [MaxRdTxns-1:0]   hit;
  logic [MaxRdTxns-1:0]   free_now;
  logic [LimW-1:0]        burst_limit [MaxRdTxns];
  logic [SlotW-1:0]       age_dec [MaxRdTxns];
  logic                   free_found;
  logic [SlotW-1:0]       free_idx;
  logic [SlotW-1:0]       alloc_age;
  read_guard_pkg::fault_t fault_d;
  read_guard_pkg::fault_t fault_q;

  assign ar_hs = ar_i.valid && ar_i.ready;
  assign r_hs  = r_i.valid && r_i.ready;

  // Per-slot status for this cycle
  always_comb begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      live[i]        = slots_q[i].state != SLOT_FREE;
      burst_limit[i] = LimW'(budgets_i.per_beat) * (LimW'(slots_q[i].len) + LimW'(1));
      first_to[i]    = (slots_q[i].state == SLOT_WAIT) &&
                       (slots_q[i].timer >= budgets_i.first_beat);
      burst_to[i]    = (slots_q[i].state == SLOT_BURST) &&
                       (LimW'(slots_q[i].timer) >= burst_limit[i]);
      // Only the oldest read of an ID can take the beat
      hit[i]         = r_hs && live[i] && (slots_q[i].id == r_i.id) &&
                       (slots_q[i].age == '0) && !first_to[i] && !burst_to[i];
      free_now[i]    = first_to[i] || burst_to[i] || (hit[i] && r_i.last);
    end
  end

  // Older same-ID slots leaving this cycle make a slot younger
  always_comb begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      age_dec[i] = '0;
      for (int j = 0; j < MaxRdTxns; j++) begin
        if (j != i && free_now[j] && live[i] && slots_q[j].id == slots_q[i].id &&
            slots_q[j].age < slots_q[i].age) begin
          age_dec[i] = age_dec[i] + SlotW'(1);
        end
      end
    end
  end

  // Lowest free slot, and the age a new read would get
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    alloc_age  = '0;
    for (int i = MaxRdTxns - 1; i >= 0; i--) begin
      if (!live[i]) begin
        free_found = 1'b1;
        free_idx   = SlotW'(i);
      end
    end
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (live[i] && !free_now[i] && slots_q[i].id == ar_i.id) begin
        alloc_age = alloc_age + SlotW'(1);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      slots_d[i] = slots_q[i];
      if (free_now[i]) begin
        slots_d[i].state = SLOT_FREE;
      end else if (live[i]) begin
        slots_d[i].age = slots_q[i].age - age_dec[i];
        if (hit[i] && slots_q[i].state == SLOT_WAIT) begin
          // First beat starts the burst budget
          slots_d[i].state = SLOT_BURST;
          slots_d[i].timer = '0;
        end else if (slots_q[i].timer != '1) begin
          slots_d[i].timer = slots_q[i].timer + 1'b1;
        end
      end
    end
    if (ar_hs && free_found) begin
      slots_d[free_idx].state = SLOT_WAIT;
      slots_d[free_idx].id    = ar_i.id;
      slots_d[free_idx].addr  = ar_i.addr;
      slots_d[free_idx].len   = ar_i.len;
      slots_d[free_idx].timer = '0;
      slots_d[free_idx].age   = alloc_age;
    end
  end

  // Lowest timed-out slot wins, then overflow
  always_comb begin
    fault_d.valid = 1'b0;
    fault_d.cause = read_guard_pkg::NONE;
    fault_d.id    = '0;
    fault_d.addr  = '0;
    for (int i = MaxRdTxns - 1; i >= 0; i--) begin
      if (first_to[i] || burst_to[i]) begin
        fault_d.valid = 1'b1;
        fault_d.cause = first_to[i] ? read_guard_pkg::FIRST_TIMEOUT :
                                      read_guard_pkg::BURST_TIMEOUT;
        fault_d.id    = slots_q[i].id;
        fault_d.addr  = slots_q[i].addr;
      end
    end
    if (!fault_d.valid && ar_hs && !free_found) begin
      fault_d.valid = 1'b1;
      fault_d.cause = read_guard_pkg::POOL_OVERFLOW;
      fault_d.id    = ar_i.id;
      fault_d.addr  = ar_i.addr;
    end
    // Keep every report a single-cycle pulse
    if (fault_q.valid) begin
      fault_d.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxRdTxns; i++) begin
        slots_q[i] <= '0;
      end
      fault_q <= '0;
    end else begin
      slots_q <= slots_d;
      fault_q <= fault_d;
    end
  end

  assign fault_o = fault_q;

  // Same-ID ordering relies on unique ages
  for (genvar a = 0; a < MaxRdTxns; a++) begin : gen_age_chk_a
    for (genvar b = a + 1; b < MaxRdTxns; b++) begin : gen_age_chk_b
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(live[a] && live[b] && slots_q[a].id == slots_q[b].id &&
          slots_q[a].age == slots_q[b].age));
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) fault_o.valid |=> !fault_o.valid);

endmodule

//--- design/stray_beat_detector.sv
`timescale 1ns/100ps

module stray_beat_detector #(
  parameter int unsigned MaxRdTxns = 4,
  parameter int unsigned IdCount   = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  read_guard_pkg::ar_mon_t ar_i,
  input  read_guard_pkg::r_mon_t  r_i,
  output read_guard_pkg::fault_t  fault_o
);

  localparam int unsigned CntW = $clog2(MaxRdTxns + 1);

  logic [CntW-1:0]        cnt_q [IdCount];
  logic [IdCount-1:0]     inc;
  logic [IdCount-1:0]     dec;
  logic                   ar_hs;
  logic                   r_hs;
  read_guard_pkg::fault_t fault_d;
  read_guard_pkg::fault_t fault_q;

  assign ar_hs = ar_i.valid && ar_i.ready;
  assign r_hs  = r_i.valid && r_i.ready;

  always_comb begin
    for (int i = 0; i < IdCount; i++) begin
      // Saturate at pool depth
      inc[i] = ar_hs && (ar_i.id == read_guard_pkg::id_t'(i)) &&
               (cnt_q[i] < CntW'(MaxRdTxns));
      dec[i] = r_hs && r_i.last && (r_i.id == read_guard_pkg::id_t'(i)) &&
               (cnt_q[i] != '0);
    end
  end

  // Any beat on an idle ID is stray
  always_comb begin
    fault_d.valid = r_hs && (cnt_q[r_i.id] == '0);
    fault_d.cause = fault_d.valid ? read_guard_pkg::STRAY_BEAT : read_guard_pkg::NONE;
    fault_d.id    = r_i.id;
    fault_d.addr  = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < IdCount; i++) begin
        cnt_q[i] <= '0;
      end
      fault_q <= '0;
    end else begin
      for (int i = 0; i < IdCount; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
      fault_q <= fault_d;
    end
  end

  assign fault_o = fault_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_hs && r_i.last && cnt_q[r_i.id] == '0) |=> (cnt_q[$past(r_i.id)] <= CntW'(1)));

endmodule

//--- design/fault_reporter.sv
`timescale 1ns/100ps

module fault_reporter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  read_guard_pkg::fault_t pool_fault_i,
  input  read_guard_pkg::fault_t stray_fault_i,
  input  logic                   reset_ack_i,
  output logic                   irq_o,
  output logic                   reset_req_o,
  output read_guard_pkg::fault_t fault_o
);

  typedef enum logic [1:0] {
    REP_IDLE,
    REP_REQ,
    REP_RELEASE
  } rep_state_e;

  rep_state_e             state_q;
  read_guard_pkg::fault_t sel_fault;
  read_guard_pkg::fault_t fault_q;

  // Pool findings take priority
  assign sel_fault = pool_fault_i.valid ? pool_fault_i : stray_fault_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= REP_IDLE;
      fault_q.valid <= 1'b0;
      fault_q.cause <= read_guard_pkg::NONE;
      fault_q.id    <= '0;
      fault_q.addr  <= '0;
    end else begin
      case (state_q)
        REP_IDLE: begin
          if (sel_fault.valid) begin
            state_q <= REP_REQ;
            fault_q <= sel_fault;
          end
        end
        // Hold the request until the system acknowledges
        REP_REQ: begin
          if (reset_ack_i) begin
            state_q <= REP_RELEASE;
          end
        end
        // Request dropped, wait for ack to go low
        REP_RELEASE: begin
          if (!reset_ack_i) begin
            state_q       <= REP_IDLE;
            fault_q.valid <= 1'b0;
          end
        end
        default: begin
          state_q <= REP_IDLE;
        end
      endcase
    end
  end

  assign irq_o       = state_q != REP_IDLE;
  assign reset_req_o = state_q == REP_REQ;
  assign fault_o     = fault_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(reset_req_o) |-> $past(reset_ack_i));

endmodule

//--- design/read_guard.sv
`timescale 1ns/100ps

module read_guard #(
  parameter int unsigned MaxRdTxns = 4,
  // Must cover every value of the ID field
  parameter int unsigned IdCount   = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  read_guard_pkg::ar_mon_t  ar_i,
  input  read_guard_pkg::r_mon_t   r_i,
  input  read_guard_pkg::budgets_t budgets_i,
  input  logic                     reset_ack_i,
  output logic                     irq_o,
  output logic                     reset_req_o,
  output read_guard_pkg::fault_t   fault_o
);

  read_guard_pkg::fault_t pool_fault;
  read_guard_pkg::fault_t stray_fault;

  read_slot_pool #(
    .MaxRdTxns (MaxRdTxns)
  ) read_slot_pool_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ar_i      (ar_i),
    .r_i       (r_i),
    .budgets_i (budgets_i),
    .fault_o   (pool_fault)
  );

  stray_beat_detector #(
    .MaxRdTxns (MaxRdTxns),
    .IdCount   (IdCount)
  ) stray_beat_detector_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ar_i    (ar_i),
    .r_i     (r_i),
    .fault_o (stray_fault)
  );

  fault_reporter fault_reporter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pool_fault_i  (pool_fault),
    .stray_fault_i (stray_fault),
    .reset_ack_i   (reset_ack_i),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .fault_o       (fault_o)
  );

endmodule

//--- bench/read_guard_tests.svh
task automatic normal_reads_test();
  read_guard_pkg::id_t   id;
  read_guard_pkg::len_t  len;
  read_guard_pkg::addr_t addr;
  start_test(16'd20, 16'd4);
  for (int i = 0; i < 4; i++) begin
    id   = read_guard_pkg::id_t'($urandom_range(15, 0));
    len  = read_guard_pkg::len_t'($urandom_range(3, 0));
    addr = $urandom;
    send_addr(id, addr, len);
    idle_cycles(2);
    send_beats(id, int'(len) + 1, 1'b1);
  end
  // Two reads in flight on one ID, answered in order
  // The older read misses its first-beat budget if the younger one takes its beats
  id = read_guard_pkg::id_t'($urandom_range(15, 0));
  send_addr(id, 32'h0000_1000, 8'd1);
  idle_cycles(8);
  send_addr(id, 32'h0000_2000, 8'd2);
  idle_cycles(1);
  send_beats(id, 2, 1'b1);
  idle_cycles(10);
  send_beats(id, 3, 1'b1);
  // Long enough for any missed timeout to fire
  idle_cycles(40);
  if (irq_seen) begin
    $display("Interrupt rose during reads that stayed within budget");
    errors++;
  end
  finish_test("normal_reads");
endtask

task automatic first_beat_timeout_test();
  int cycles;
  start_test(16'd10, 16'd4);
  send_addr(4'h9, 32'hA5A5_0040, 8'd0);
  wait_irq(40, cycles);
  if (cycles < 10 || cycles > 14) begin
    $display("Interrupt came %0d cycles after the address, outside 10 to 14", cycles);
    errors++;
  end
  if (fault.cause !== read_guard_pkg::FIRST_TIMEOUT) begin
    report_mismatch("fault_o.cause", 32'(fault.cause), 32'(read_guard_pkg::FIRST_TIMEOUT));
  end
  if (fault.id !== 4'h9) begin
    report_mismatch("fault_o.id", 32'(fault.id), 32'h9);
  end
  if (fault.addr !== 32'hA5A5_0040) begin
    report_mismatch("fault_o.addr", fault.addr, 32'hA5A5_0040);
  end
  finish_test("first_beat_timeout");
endtask

task automatic burst_timeout_test();
  int cycles;
  start_test(16'd10, 16'd4);
  send_addr(4'h3, 32'h0000_8800, 8'd3);
  idle_cycles(2);
  // First beat only, the rest of the burst is withheld
  send_beats(4'h3, 1, 1'b0);
  wait_irq(60, cycles);
  if (cycles < 16 || cycles > 20) begin
    $display("Interrupt came %0d cycles after the first beat, outside 16 to 20", cycles);
    errors++;
  end
  if (fault.cause !== read_guard_pkg::BURST_TIMEOUT) begin
    report_mismatch("fault_o.cause", 32'(fault.cause), 32'(read_guard_pkg::BURST_TIMEOUT));
  end
  if (fault.id !== 4'h3) begin
    report_mismatch("fault_o.id", 32'(fault.id), 32'h3);
  end
  if (fault.addr !== 32'h0000_8800) begin
    report_mismatch("fault_o.addr", fault.addr, 32'h0000_8800);
  end
  finish_test("burst_timeout");
endtask

task automatic stray_beat_test();
  int cycles;
  start_test(16'd10, 16'd4);
  send_beats(4'h5, 1, 1'b1);
  wait_irq(10, cycles);
  if (fault.cause !== read_guard_pkg::STRAY_BEAT) begin
    report_mismatch("fault_o.cause", 32'(fault.cause), 32'(read_guard_pkg::STRAY_BEAT));
  end
  if (fault.id !== 4'h5) begin
    report_mismatch("fault_o.id", 32'(fault.id), 32'h5);
  end
  finish_test("stray_beat");
endtask

task automatic pool_overflow_test();
  int cycles;
  start_test(16'd100, 16'd4);
  for (int i = 0; i < 4; i++) begin
    send_addr(read_guard_pkg::id_t'(i), 32'h0000_0100 * i, 8'd0);
  end
  send_addr(4'hC, 32'hFEED_0500, 8'd0);
  wait_irq(10, cycles);
  if (fault.cause !== read_guard_pkg::POOL_OVERFLOW) begin
    report_mismatch("fault_o.cause", 32'(fault.cause), 32'(read_guard_pkg::POOL_OVERFLOW));
  end
  if (fault.addr !== 32'hFEED_0500) begin
    report_mismatch("fault_o.addr", fault.addr, 32'hFEED_0500);
  end
  finish_test("pool_overflow");
endtask

task automatic reset_handshake_test();
  int cycles;
  start_test(16'd10, 16'd4);
  send_beats(4'h2, 1, 1'b1);
  wait_irq(10, cycles);
  if (reset_req !== 1'b1) begin
    report_mismatch("reset_req_o", 32'(reset_req), 32'h1);
  end
  ack_reset();
  if (fault.valid !== 1'b0) begin
    report_mismatch("fault_o.valid", 32'(fault.valid), 32'h0);
  end
  // A new fault after the handshake is reported again
  send_beats(4'h7, 1, 1'b1);
  wait_irq(10, cycles);
  if (fault.cause !== read_guard_pkg::STRAY_BEAT) begin
    report_mismatch("fault_o.cause", 32'(fault.cause), 32'(read_guard_pkg::STRAY_BEAT));
  end
  if (fault.id !== 4'h7) begin
    report_mismatch("fault_o.id", 32'(fault.id), 32'h7);
  end
  ack_reset();
  if (reset_req !== 1'b0) begin
    report_mismatch("reset_req_o", 32'(reset_req), 32'h0);
  end
  finish_test("reset_handshake");
endtask

//--- bench/read_guard_tb.sv
`timescale 1ns/100ps

module read_guard_tb;

  logic                     clk;
  logic                     rst_n;
  read_guard_pkg::ar_mon_t  ar;
  read_guard_pkg::r_mon_t   r;
  read_guard_pkg::budgets_t budgets;
  logic                     reset_ack;
  logic                     irq;
  logic                     reset_req;
  read_guard_pkg::fault_t   fault;

  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;
  logic        irq_seen;

  read_guard #(
    .MaxRdTxns (4),
    .IdCount   (16)
  ) read_guard_inst (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .ar_i        (ar),
    .r_i         (r),
    .budgets_i   (budgets),
    .reset_ack_i (reset_ack),
    .irq_o       (irq),
    .reset_req_o (reset_req),
    .fault_o     (fault)
  );

  always #10 clk = ~clk;

  // Any interrupt since the last test start
  always @(negedge clk) begin
    if (irq) begin
      irq_seen = 1'b1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic apply_reset();
    ar        = '0;
    r         = '0;
    reset_ack = 1'b0;
    rst_n     = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One address handshake, taken at the next rising edge
  task automatic send_addr(input read_guard_pkg::id_t id, input read_guard_pkg::addr_t addr,
                           input read_guard_pkg::len_t len);
    ar.valid = 1'b1;
    ar.ready = 1'b1;
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = len;
    @(negedge clk);
    ar.valid = 1'b0;
  endtask

  task automatic send_beats(input read_guard_pkg::id_t id, input int count, input logic with_last);
    for (int i = 0; i < count; i++) begin
      r.valid = 1'b1;
      r.ready = 1'b1;
      r.id    = id;
      r.last  = with_last && (i == count - 1);
      @(negedge clk);
    end
    r.valid = 1'b0;
    r.last  = 1'b0;
  endtask

  task automatic wait_irq(input int limit, output int cycles);
    cycles = 0;
    while (!irq && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!irq) begin
      $display("Interrupt did not rise within %0d cycles", limit);
      errors++;
    end
  endtask

  // System side of the four-phase reset handshake
  task automatic ack_reset();
    int cycles;
    cycles = 0;
    while (!reset_req && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!reset_req) begin
      $display("Reset request never rose");
      errors++;
    end
    reset_ack = 1'b1;
    cycles = 0;
    while (reset_req && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (reset_req) begin
      $display("Reset request stayed high after the acknowledge");
      errors++;
    end
    if (!irq) begin
      $display("Interrupt dropped before the acknowledge was released");
      errors++;
    end
    reset_ack = 1'b0;
    cycles = 0;
    while (irq && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (irq) begin
      $display("Interrupt stayed high after the handshake ended");
      errors++;
    end
  endtask

  task automatic start_test(input read_guard_pkg::cnt_t first_beat,
                            input read_guard_pkg::cnt_t per_beat);
    budgets.first_beat = first_beat;
    budgets.per_beat   = per_beat;
    apply_reset();
    errors_at_start = errors;
    irq_seen        = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  `include "read_guard_tests.svh"

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ar           = '0;
    r            = '0;
    budgets      = '0;
    reset_ack    = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    irq_seen     = 1'b0;
    void'($urandom(32'h3454_612e));
    @(negedge clk);
    normal_reads_test();
    first_beat_timeout_test();
    burst_timeout_test();
    stray_beat_test();
    pool_overflow_test();
    reset_handshake_test();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+bench
design/read_guard_pkg.sv
design/read_slot_pool.sv
design/stray_beat_detector.sv
design/fault_reporter.sv
design/read_guard.sv
bench/read_guard_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module read_guard_tb \
  -f filelist.f -o sim_read_guard

out=$(./obj_dir/sim_read_guard)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
